/* rtl/alloc_pkg.sv */
package alloc_pkg;

    // ====================
    // Widths
    // ====================
    localparam int PTR_WID        = 5;
    localparam int BUFFER_SIZE    = 64;
    localparam int SIZE_WID       = 6;
    localparam int META_WID       = 4;
    localparam int FRAME_SIZE_WID = 12;

    // ====================
    // Datapath structs
    // ====================
    // Size counts only on the eof buffer
    typedef struct packed {
        logic                eof;
        logic [SIZE_WID-1:0] size;
        logic [META_WID-1:0] meta;
        logic                err;
    } alloc_desc_t;

    typedef struct packed {
        logic [PTR_WID-1:0] ptr;
        alloc_desc_t        desc;
    } store_beat_t;

    typedef struct packed {
        logic [PTR_WID-1:0] ptr;
        alloc_desc_t        desc;
    } load_beat_t;

    typedef struct packed {
        logic [PTR_WID-1:0]        head;
        logic [FRAME_SIZE_WID-1:0] size;
    } frame_t;

    // Single-cycle pulses into the statistics counters
    typedef struct packed {
        logic alloc;
        logic alloc_err;
        logic dealloc;
        logic dealloc_err;
        logic frame;
    } alloc_evt_t;

    // ====================
    // APB
    // ====================
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [7:0] {
        REG_CTRL        = 8'h00,
        REG_STATUS      = 8'h04,
        REG_ACTIVE      = 8'h08,
        REG_ALLOC       = 8'h0C,
        REG_ALLOC_ERR   = 8'h10,
        REG_DEALLOC     = 8'h14,
        REG_DEALLOC_ERR = 8'h18,
        REG_FRAMES      = 8'h1C
    } alloc_reg_e;

    // ====================
    // FSM states
    // ====================
    typedef enum logic {FL_INIT, FL_RUN} fl_state_e;

    typedef enum logic [1:0] {G_IDLE, G_READ, G_OUT} gather_state_e;

endpackage

/* rtl/alloc_ram.sv */
module alloc_ram #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read-before-write on an address collision
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* rtl/alloc_free_list.sv */
module alloc_free_list #(
    parameter int NUM_BUFS = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          en,
    output logic                          init_done,
    output logic                          ptr_valid,
    input  logic                          ptr_ready,
    output logic [alloc_pkg::PTR_WID-1:0] ptr,
    input  logic [alloc_pkg::PTR_WID-1:0] chk_ptr,
    output logic                          chk_alloc,
    input  logic                          fr_valid,
    input  logic [alloc_pkg::PTR_WID-1:0] fr_ptr,
    input  logic                          rc_valid,
    output logic                          rc_ready,
    input  logic [alloc_pkg::PTR_WID-1:0] rc_ptr,
    output alloc_pkg::alloc_evt_t         evt
);

    localparam int PW    = alloc_pkg::PTR_WID;
    localparam int DEPTH = 2 ** PW;

    if (NUM_BUFS > DEPTH) begin : g_bad_num_bufs
        $error("NUM_BUFS exceeds the pointer space");
    end

    alloc_pkg::fl_state_e state;
    logic [PW-1:0]        fifo [DEPTH];
    logic [PW-1:0]        rd_idx;
    logic [PW-1:0]        wr_idx;
    logic [PW:0]          count;
    logic [DEPTH-1:0]     alloc_map;
    logic                 pop;
    logic                 free_req;
    logic                 free_err;
    logic                 push;
    logic [PW-1:0]        free_ptr;
    logic [PW-1:0]        push_ptr;

    assign init_done = (state == alloc_pkg::FL_RUN);
    assign ptr_valid = init_done && en && (count != '0);
    assign ptr       = fifo[rd_idx];
    assign pop       = ptr_valid && ptr_ready;
    assign chk_alloc = alloc_map[chk_ptr];

    // Gather frees always win over recycle
    assign rc_ready = init_done && !fr_valid;
    assign free_req = fr_valid || (rc_valid && rc_ready);
    assign free_ptr = fr_valid ? fr_ptr : rc_ptr;
    assign free_err = free_req && !alloc_map[free_ptr];

    // Init fill pushes 0..NUM_BUFS-1 straight from the count
    assign push     = !init_done || (free_req && alloc_map[free_ptr]);
    assign push_ptr = init_done ? free_ptr : count[PW-1:0];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_idx] <= push_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= alloc_pkg::FL_INIT;
            rd_idx    <= '0;
            wr_idx    <= '0;
            count     <= '0;
            alloc_map <= '0;
            evt       <= '0;
        end else begin
            if (!init_done && count == (PW + 1)'(NUM_BUFS - 1)) begin
                state <= alloc_pkg::FL_RUN;
            end
            if (push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx         <= rd_idx + 1'b1;
                alloc_map[ptr] <= 1'b1;
            end
            if (push && init_done) begin
                alloc_map[free_ptr] <= 1'b0;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            evt <= '{alloc: pop, alloc_err: 1'b0, dealloc: push && init_done,
                     dealloc_err: free_err, frame: 1'b0};
        end
    end

    // Popped pointer must be queued and not already out
    assert property (@(posedge clk) disable iff (reset)
        pop |-> (count != '0) && !alloc_map[ptr]);

    // Only allocated pointers come back, so the queue cannot overfill
    assert property (@(posedge clk) disable iff (reset)
        push && !pop |-> count < (PW + 1)'(NUM_BUFS));

endmodule

/* rtl/alloc_scatter.sv */
module alloc_scatter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          init_done,
    input  logic                          st_valid,
    output logic                          st_ready,
    input  alloc_pkg::store_beat_t        st,
    output logic [alloc_pkg::PTR_WID-1:0] chk_ptr,
    input  logic                          chk_alloc,
    output logic                          desc_we,
    output logic [alloc_pkg::PTR_WID-1:0] desc_waddr,
    output alloc_pkg::alloc_desc_t        desc_wdata,
    output logic                          link_we,
    output logic [alloc_pkg::PTR_WID-1:0] link_waddr,
    output logic [alloc_pkg::PTR_WID-1:0] link_wdata,
    output logic                          frame_valid,
    output alloc_pkg::frame_t             frame,
    output alloc_pkg::alloc_evt_t         evt
);

    localparam int FW = alloc_pkg::FRAME_SIZE_WID;

    logic                          accept;
    logic                          store;
    logic                          in_frame;
    logic [alloc_pkg::PTR_WID-1:0] head_ptr;
    logic [alloc_pkg::PTR_WID-1:0] prev_ptr;
    logic [FW-1:0]                 byte_cnt;
    logic [FW:0]                   beat_bytes;
    logic [FW:0]                   next_cnt;

    assign st_ready = init_done;
    assign accept   = st_valid && st_ready;
    assign chk_ptr  = st.ptr;
    assign store    = accept && chk_alloc;

    assign desc_we    = store;
    assign desc_waddr = st.ptr;
    assign desc_wdata = st.desc;

    // Chain behind the previous buffer of the open frame
    assign link_we    = store && in_frame;
    assign link_waddr = prev_ptr;
    assign link_wdata = st.ptr;

    assign beat_bytes = st.desc.eof ? (FW + 1)'(st.desc.size)
                                    : (FW + 1)'(alloc_pkg::BUFFER_SIZE);
    assign next_cnt   = (in_frame ? {1'b0, byte_cnt} : '0) + beat_bytes;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame    <= 1'b0;
            frame_valid <= 1'b0;
            evt         <= '0;
        end else begin
            frame_valid <= store && st.desc.eof;
            evt <= '{alloc: 1'b0, alloc_err: accept && !chk_alloc, dealloc: 1'b0,
                     dealloc_err: 1'b0, frame: store && st.desc.eof};
            if (store) begin
                in_frame <= !st.desc.eof;
            end
        end
    end

    // Open frame context and report payload
    always_ff @(posedge clk) begin
        if (store) begin
            if (!in_frame) begin
                head_ptr <= st.ptr;
            end
            prev_ptr   <= st.ptr;
            byte_cnt   <= next_cnt[FW-1:0];
            frame.head <= in_frame ? head_ptr : st.ptr;
            frame.size <= next_cnt[FW-1:0];
        end
    end

    // Running total over a whole frame fits FRAME_SIZE_WID
    assert property (@(posedge clk) disable iff (reset)
        store |-> !next_cnt[FW]);

endmodule

/* rtl/alloc_gather.sv */
module alloc_gather (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          lr_valid,
    output logic                          lr_ready,
    input  logic [alloc_pkg::PTR_WID-1:0] lr_ptr,
    output logic                          rd_en,
    output logic [alloc_pkg::PTR_WID-1:0] rd_addr,
    input  alloc_pkg::alloc_desc_t        desc_rdata,
    input  logic [alloc_pkg::PTR_WID-1:0] link_rdata,
    output logic                          ld_valid,
    input  logic                          ld_ready,
    output alloc_pkg::load_beat_t         ld,
    output logic                          fr_valid,
    output logic [alloc_pkg::PTR_WID-1:0] fr_ptr
);

    alloc_pkg::gather_state_e      state;
    logic [alloc_pkg::PTR_WID-1:0] rd_ptr;
    logic [alloc_pkg::PTR_WID-1:0] link_ptr;
    logic                          start;
    logic                          accept;

    assign lr_ready = (state == alloc_pkg::G_IDLE);
    assign start    = lr_valid && lr_ready;
    assign ld_valid = (state == alloc_pkg::G_OUT);
    assign accept   = ld_valid && ld_ready;

    // Buffer goes back to the free list as its beat leaves
    assign fr_valid = accept;
    assign fr_ptr   = ld.ptr;

    // Both RAMs read together, head from request or next from link
    assign rd_en   = start || (accept && !ld.desc.eof);
    assign rd_addr = lr_ready ? lr_ptr : link_ptr;

    // ====================
    // Chain walk FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= alloc_pkg::G_IDLE;
        end else begin
            case (state)
                alloc_pkg::G_IDLE: begin
                    if (start) begin
                        state <= alloc_pkg::G_READ;
                    end
                end
                alloc_pkg::G_READ: begin
                    state <= alloc_pkg::G_OUT;
                end
                alloc_pkg::G_OUT: begin
                    if (accept) begin
                        state <= ld.desc.eof ? alloc_pkg::G_IDLE : alloc_pkg::G_READ;
                    end
                end
                default: begin
                    state <= alloc_pkg::G_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_ptr <= rd_addr;
        end
        if (state == alloc_pkg::G_READ) begin
            ld       <= '{ptr: rd_ptr, desc: desc_rdata};
            link_ptr <= link_rdata;
        end
    end

    // Stalled beat holds until taken
    assert property (@(posedge clk) disable iff (reset)
        ld_valid && !ld_ready |=> ld_valid && $stable(ld));

endmodule

/* rtl/alloc_ctrl.sv */
module alloc_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  alloc_pkg::apb_req_t   req,
    output alloc_pkg::apb_rsp_t   rsp,
    input  logic                  init_done,
    input  alloc_pkg::alloc_evt_t fl_evt,
    input  alloc_pkg::alloc_evt_t sc_evt,
    output logic                  en
);

    alloc_pkg::alloc_evt_t evt;
    logic                  access;
    logic                  hit;
    logic [31:0]           rdata;
    logic [31:0]           active_cnt;
    logic [31:0]           alloc_cnt;
    logic [31:0]           alloc_err_cnt;
    logic [31:0]           dealloc_cnt;
    logic [31:0]           dealloc_err_cnt;
    logic [31:0]           frame_cnt;

    // Each source drives its own fields, the rest stay 0
    assign evt    = fl_evt | sc_evt;
    assign access = req.psel && req.penable;

    // ====================
    // Register decode
    // ====================
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (req.paddr)
            alloc_pkg::REG_CTRL:        rdata = {31'b0, en};
            alloc_pkg::REG_STATUS:      rdata = {31'b0, init_done};
            alloc_pkg::REG_ACTIVE:      rdata = active_cnt;
            alloc_pkg::REG_ALLOC:       rdata = alloc_cnt;
            alloc_pkg::REG_ALLOC_ERR:   rdata = alloc_err_cnt;
            alloc_pkg::REG_DEALLOC:     rdata = dealloc_cnt;
            alloc_pkg::REG_DEALLOC_ERR: rdata = dealloc_err_cnt;
            alloc_pkg::REG_FRAMES:      rdata = frame_cnt;
            default:                    hit = 1'b0;
        endcase
    end

    assign rsp.prdata  = (access && !req.pwrite) ? rdata : '0;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = access && !hit;

    // ====================
    // Enable and counters
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            en              <= 1'b1;
            active_cnt      <= '0;
            alloc_cnt       <= '0;
            alloc_err_cnt   <= '0;
            dealloc_cnt     <= '0;
            dealloc_err_cnt <= '0;
            frame_cnt       <= '0;
        end else begin
            if (access && req.pwrite && req.paddr == alloc_pkg::REG_CTRL) begin
                en <= req.pwdata[0];
            end
            // Alloc and free in one cycle cancel out
            if (evt.alloc && !evt.dealloc) begin
                active_cnt <= active_cnt + 1'b1;
            end else if (evt.dealloc && !evt.alloc) begin
                active_cnt <= active_cnt - 1'b1;
            end
            alloc_cnt       <= alloc_cnt + 32'(evt.alloc);
            alloc_err_cnt   <= alloc_err_cnt + 32'(evt.alloc_err);
            dealloc_cnt     <= dealloc_cnt + 32'(evt.dealloc);
            dealloc_err_cnt <= dealloc_err_cnt + 32'(evt.dealloc_err);
            frame_cnt       <= frame_cnt + 32'(evt.frame);
        end
    end

endmodule

/* rtl/alloc_top.sv */
module alloc_top #(
    parameter int NUM_BUFS = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          ptr_valid,
    input  logic                          ptr_ready,
    output logic [alloc_pkg::PTR_WID-1:0] ptr,
    input  logic                          st_valid,
    output logic                          st_ready,
    input  alloc_pkg::store_beat_t        st,
    output logic                          frame_valid,
    output alloc_pkg::frame_t             frame,
    input  logic                          lr_valid,
    output logic                          lr_ready,
    input  logic [alloc_pkg::PTR_WID-1:0] lr_ptr,
    output logic                          ld_valid,
    input  logic                          ld_ready,
    output alloc_pkg::load_beat_t         ld,
    input  logic                          rc_valid,
    output logic                          rc_ready,
    input  logic [alloc_pkg::PTR_WID-1:0] rc_ptr,
    input  alloc_pkg::apb_req_t           req,
    output alloc_pkg::apb_rsp_t           rsp
);

    localparam int PW    = alloc_pkg::PTR_WID;
    localparam int DEPTH = 2 ** PW;

    logic                   en;
    logic                   init_done;
    alloc_pkg::alloc_evt_t  fl_evt;
    alloc_pkg::alloc_evt_t  sc_evt;
    logic [PW-1:0]          chk_ptr;
    logic                   chk_alloc;
    logic                   fr_valid;
    logic [PW-1:0]          fr_ptr;
    logic                   desc_we;
    logic [PW-1:0]          desc_waddr;
    alloc_pkg::alloc_desc_t desc_wdata;
    alloc_pkg::alloc_desc_t desc_rdata;
    logic                   link_we;
    logic [PW-1:0]          link_waddr;
    logic [PW-1:0]          link_wdata;
    logic [PW-1:0]          link_rdata;
    logic                   rd_en;
    logic [PW-1:0]          rd_addr;

    alloc_ctrl alloc_ctrl_i (
        .clk, .reset, .req, .rsp, .init_done, .fl_evt, .sc_evt, .en
    );

    alloc_free_list #(
        .NUM_BUFS(NUM_BUFS)
    ) alloc_free_list_i (
        .clk, .reset, .en, .init_done, .ptr_valid, .ptr_ready, .ptr,
        .chk_ptr, .chk_alloc, .fr_valid, .fr_ptr,
        .rc_valid, .rc_ready, .rc_ptr, .evt(fl_evt)
    );

    alloc_scatter alloc_scatter_i (
        .clk, .reset, .init_done, .st_valid, .st_ready, .st,
        .chk_ptr, .chk_alloc, .desc_we, .desc_waddr, .desc_wdata,
        .link_we, .link_waddr, .link_wdata, .frame_valid, .frame, .evt(sc_evt)
    );

    alloc_gather alloc_gather_i (
        .clk, .reset, .lr_valid, .lr_ready, .lr_ptr, .rd_en, .rd_addr,
        .desc_rdata, .link_rdata, .ld_valid, .ld_ready, .ld, .fr_valid, .fr_ptr
    );

    alloc_ram #(
        .WIDTH($bits(alloc_pkg::alloc_desc_t)),
        .DEPTH(DEPTH)
    ) desc_ram (
        .clk, .we(desc_we), .waddr(desc_waddr), .wdata(desc_wdata),
        .re(rd_en), .raddr(rd_addr), .rdata(desc_rdata)
    );

    alloc_ram #(
        .WIDTH(PW),
        .DEPTH(DEPTH)
    ) link_ram (
        .clk, .we(link_we), .waddr(link_waddr), .wdata(link_wdata),
        .re(rd_en), .raddr(rd_addr), .rdata(link_rdata)
    );

endmodule

/* tests/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* tests/alloc_tb.sv */
module alloc_tb;

    localparam int NUM_BUFS = 16;
    localparam int PW       = alloc_pkg::PTR_WID;
    localparam int SW       = alloc_pkg::SIZE_WID;
    localparam int MW       = alloc_pkg::META_WID;
    localparam int FW       = alloc_pkg::FRAME_SIZE_WID;

    // Cycle budgets per test and the watchdog limit built from them
    localparam int BUDGET_INIT    = 120;
    localparam int BUDGET_SINGLE  = 60;
    localparam int BUDGET_MULTI   = 800;
    localparam int BUDGET_ERR     = 40;
    localparam int BUDGET_RECYCLE = 200;
    localparam int BUDGET_REGS    = 100;
    localparam int WATCHDOG_CYCLES = 40 * (BUDGET_INIT + BUDGET_SINGLE + BUDGET_MULTI
                                           + BUDGET_ERR + BUDGET_RECYCLE + BUDGET_REGS);

    typedef logic [PW-1:0] ptr_q_t[$];
    typedef alloc_pkg::alloc_desc_t desc_q_t[$];

    logic                   clk;
    logic                   reset;
    logic                   ptr_valid;
    logic                   ptr_ready;
    logic [PW-1:0]          ptr;
    logic                   st_valid;
    logic                   st_ready;
    alloc_pkg::store_beat_t st;
    logic                   frame_valid;
    alloc_pkg::frame_t      frame;
    logic                   lr_valid;
    logic                   lr_ready;
    logic [PW-1:0]          lr_ptr;
    logic                   ld_valid;
    logic                   ld_ready;
    alloc_pkg::load_beat_t  ld;
    logic                   rc_valid;
    logic                   rc_ready;
    logic [PW-1:0]          rc_ptr;
    alloc_pkg::apb_req_t    req;
    alloc_pkg::apb_rsp_t    rsp;

    // Reference state
    logic [PW-1:0]          free_q[$];
    bit                     held [2**PW];
    alloc_pkg::frame_t      exp_frame_q[$];
    alloc_pkg::load_beat_t  exp_beat_q[$];
    logic [31:0]            exp_rd_q[$];
    bit                     exp_err_q[$];
    int                     m_active;
    int                     m_alloc;
    int                     m_alloc_err;
    int                     m_dealloc;
    int                     m_dealloc_err;
    int                     m_frames;
    int                     errors;
    int                     checks;
    logic [31:0]            lcg_state;

    tb_clock_gen #(.PERIOD(4)) clock_i (.clk);

    alloc_top #(
        .NUM_BUFS(NUM_BUFS)
    ) alloc_top_i (
        .clk, .reset, .ptr_valid, .ptr_ready, .ptr, .st_valid, .st_ready, .st,
        .frame_valid, .frame, .lr_valid, .lr_ready, .lr_ptr, .ld_valid, .ld_ready,
        .ld, .rc_valid, .rc_ready, .rc_ptr, .req, .rsp
    );

    // ====================
    // Helpers
    // ====================
    function automatic int rand_range(input int lo, input int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'(lcg_state[31:16]) % (hi - lo + 1);
    endfunction

    // Frame size is full buffers plus the tail size of the eof buffer
    function automatic alloc_pkg::frame_t ref_frame(input logic [PW-1:0] head,
                                                    input desc_q_t descs);
        alloc_pkg::frame_t f;
        int total;
        total = 0;
        foreach (descs[i]) begin
            total += descs[i].eof ? int'(descs[i].size) : alloc_pkg::BUFFER_SIZE;
        end
        f.head = head;
        f.size = FW'(total);
        return f;
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED t=%0t: %s", $time, msg);
    endtask

    task automatic flag_protocol(input string msg);
        errors++;
        $display("ERROR at t=%0t: %s", $time, msg);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic take_ptr(output logic [PW-1:0] p);
        logic [PW-1:0] exp_p;
        ptr_ready = 1'b1;
        #1;
        while (!ptr_valid) begin
            @(negedge clk);
            #1;
        end
        exp_p = free_q.pop_front();
        checks++;
        assert (ptr == exp_p) else
            flag_mismatch($sformatf("pointer got %0d exp %0d", ptr, exp_p));
        p = ptr;
        held[p] = 1'b1;
        m_alloc++;
        m_active++;
        @(negedge clk);
        ptr_ready = 1'b0;
    endtask

    task automatic check_ptr_valid_low(input int n);
        repeat (n) begin
            #1;
            checks++;
            assert (!ptr_valid) else flag_mismatch("ptr_valid high while it should be low");
            @(negedge clk);
        end
    endtask

    task automatic store_beat(input logic [PW-1:0] p, input alloc_pkg::alloc_desc_t d);
        st_valid = 1'b1;
        st.ptr   = p;
        st.desc  = d;
        #1;
        while (!st_ready) begin
            @(negedge clk);
            #1;
        end
        if (!held[p]) begin
            m_alloc_err++;
        end
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic store_frame(input int n, output ptr_q_t ptrs);
        desc_q_t               descs;
        alloc_pkg::alloc_desc_t d;
        alloc_pkg::load_beat_t b;
        logic [PW-1:0]         p;
        ptrs  = {};
        descs = {};
        for (int i = 0; i < n; i++) begin
            take_ptr(p);
            ptrs.push_back(p);
        end
        for (int i = 0; i < n; i++) begin
            d.eof  = (i == n - 1);
            d.size = SW'(d.eof ? rand_range(1, 63) : rand_range(0, 63));
            d.meta = MW'(rand_range(0, 15));
            d.err  = (rand_range(0, 7) == 0);
            descs.push_back(d);
            b.ptr  = ptrs[i];
            b.desc = d;
            exp_beat_q.push_back(b);
        end
        exp_frame_q.push_back(ref_frame(ptrs[0], descs));
        m_frames++;
        for (int i = 0; i < n; i++) begin
            store_beat(ptrs[i], descs[i]);
        end
    endtask

    // Walk one frame and free each buffer as its beat is accepted
    task automatic load_frame(input ptr_q_t ptrs, input bit stall);
        int got;
        lr_valid = 1'b1;
        lr_ptr   = ptrs[0];
        #1;
        while (!lr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        lr_valid = 1'b0;
        got = 0;
        while (got < ptrs.size()) begin
            ld_ready = stall ? (rand_range(0, 3) != 0) : 1'b1;
            #1;
            if (ld_valid && ld_ready) begin
                free_q.push_back(ptrs[got]);
                held[ptrs[got]] = 1'b0;
                m_dealloc++;
                m_active--;
                got++;
            end
            @(negedge clk);
        end
        ld_ready = 1'b0;
    endtask

    task automatic recycle(input logic [PW-1:0] p);
        rc_valid = 1'b1;
        rc_ptr   = p;
        #1;
        while (!rc_ready) begin
            @(negedge clk);
            #1;
        end
        if (held[p]) begin
            held[p] = 1'b0;
            free_q.push_back(p);
            m_dealloc++;
            m_active--;
        end else begin
            m_dealloc_err++;
        end
        @(negedge clk);
        rc_valid = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input bit exp_err);
        exp_rd_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(negedge clk);
        req.penable = 1'b1;
        @(negedge clk);
        req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input bit exp_err);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        req.penable = 1'b1;
        #1;
        checks++;
        assert (rsp.pslverr == exp_err && rsp.pready) else
            flag_mismatch($sformatf("write 0x%02h pslverr %b pready %b exp %b/1", addr,
                                    rsp.pslverr, rsp.pready, exp_err));
        @(negedge clk);
        req = '0;
    endtask

    task automatic check_counters();
        idle(3);
        apb_read(alloc_pkg::REG_ACTIVE, m_active, 1'b0);
        apb_read(alloc_pkg::REG_ALLOC, m_alloc, 1'b0);
        apb_read(alloc_pkg::REG_ALLOC_ERR, m_alloc_err, 1'b0);
        apb_read(alloc_pkg::REG_DEALLOC, m_dealloc, 1'b0);
        apb_read(alloc_pkg::REG_DEALLOC_ERR, m_dealloc_err, 1'b0);
        apb_read(alloc_pkg::REG_FRAMES, m_frames, 1'b0);
    endtask

    // ====================
    // Compare process
    // ====================
    initial begin
        alloc_pkg::frame_t     ef;
        alloc_pkg::load_beat_t eb;
        logic [31:0]           ed;
        bit                    ee;
        forever begin
            @(negedge clk);
            #1;
            if (frame_valid) begin
                if (exp_frame_q.size() == 0) begin
                    flag_protocol("frame report with no frame expected");
                end else begin
                    ef = exp_frame_q.pop_front();
                    checks++;
                    assert (frame == ef) else
                        flag_mismatch($sformatf("frame got head %0d size %0d exp %0d %0d",
                                                frame.head, frame.size, ef.head, ef.size));
                end
            end
            if (ld_valid && ld_ready) begin
                if (exp_beat_q.size() == 0) begin
                    flag_protocol("load beat with no beat expected");
                end else begin
                    eb = exp_beat_q.pop_front();
                    checks++;
                    assert (ld == eb) else
                        flag_mismatch($sformatf("load beat got %h exp %h", ld, eb));
                end
            end
            if (req.psel && req.penable && !req.pwrite) begin
                ed = exp_rd_q.pop_front();
                ee = exp_err_q.pop_front();
                checks++;
                assert (rsp.prdata == ed && rsp.pslverr == ee && rsp.pready) else
                    flag_mismatch($sformatf("read 0x%02h got %0d/%b/%b exp %0d/%b/1",
                                            req.paddr, rsp.prdata, rsp.pslverr,
                                            rsp.pready, ed, ee));
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the simulation hung and did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        logic [PW-1:0] p;
        logic [PW-1:0] last;
        ptr_q_t        ptrs;
        lcg_state = 32'd61;
        reset     = 1'b1;
        ptr_ready = 1'b0;
        st_valid  = 1'b0;
        st        = '0;
        lr_valid  = 1'b0;
        lr_ptr    = '0;
        ld_ready  = 1'b0;
        rc_valid  = 1'b0;
        rc_ptr    = '0;
        req       = '0;
        errors    = 0;
        checks    = 0;
        m_active      = 0;
        m_alloc       = 0;
        m_alloc_err   = 0;
        m_dealloc     = 0;
        m_dealloc_err = 0;
        m_frames      = 0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            free_q.push_back(PW'(i));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Init and allocation
        while (!ptr_valid) begin
            @(negedge clk);
        end
        apb_read(alloc_pkg::REG_STATUS, 32'd1, 1'b0);
        for (int i = 0; i < NUM_BUFS; i++) begin
            take_ptr(p);
        end
        check_ptr_valid_low(10);
        check_counters();
        for (int i = 0; i < NUM_BUFS; i++) begin
            recycle(PW'(i));
        end
        check_counters();

        // Single-buffer frame
        store_frame(1, ptrs);
        load_frame(ptrs, 1'b0);
        check_counters();

        // Multi-buffer frames with random ld_ready stalls
        for (int f = 0; f < 4; f++) begin
            store_frame(rand_range(2, 6), ptrs);
            load_frame(ptrs, 1'b1);
        end
        check_counters();

        // Store to a pointer that was never handed out
        store_beat(PW'(20), '{eof: 1'b1, size: SW'(8), meta: MW'(3), err: 1'b0});
        check_counters();

        // Recycle, double free, then FIFO reuse order
        take_ptr(p);
        recycle(p);
        recycle(p);
        check_counters();
        for (int i = 0; i < NUM_BUFS; i++) begin
            take_ptr(last);
        end
        checks++;
        assert (last == p) else
            flag_mismatch($sformatf("recycled pointer %0d not handed out last", p));
        for (int i = 0; i < NUM_BUFS; i++) begin
            recycle(PW'(i));
        end
        check_counters();

        // Enable bit and bad address
        apb_write(alloc_pkg::REG_CTRL, 32'd0, 1'b0);
        apb_read(alloc_pkg::REG_CTRL, 32'd0, 1'b0);
        check_ptr_valid_low(20);
        apb_write(alloc_pkg::REG_CTRL, 32'd1, 1'b0);
        #1;
        checks++;
        assert (ptr_valid) else flag_mismatch("ptr_valid still low after enable");
        @(negedge clk);
        apb_read(8'h40, 32'd0, 1'b1);
        apb_write(8'h40, 32'd0, 1'b1);
        apb_read(alloc_pkg::REG_CTRL, 32'd1, 1'b0);
        check_counters();
        idle(4);

        if (exp_frame_q.size() != 0 || exp_beat_q.size() != 0 || exp_rd_q.size() != 0) begin
            flag_protocol("expected frame reports, beats or reads never arrived");
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/alloc_pkg.sv
rtl/alloc_ram.sv
rtl/alloc_free_list.sv
rtl/alloc_scatter.sv
rtl/alloc_gather.sv
rtl/alloc_ctrl.sv
rtl/alloc_top.sv
tests/tb_clock_gen.sv
tests/alloc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the allocator testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module alloc_tb \
        -Mdir obj_dir -o alloc_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/alloc_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
